// File: compile.f
verilog/frame_wr_pkg.sv
verilog/frame_wr_ctrl.sv
verilog/chan_addr_gen.sv
verilog/buf_rd_addr.sv
verilog/burst_beat.sv
verilog/frame_wr_top.sv
tests/frame_wr_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the frame-store write arbiter testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module frame_wr_tb -Mdir obj_dir -f compile.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vframe_wr_tb)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qF "*** TEST PASSED ***"; then
    exit 0
fi
exit 1

// File: tests/frame_wr_tb.sv
/*
 * Testbench for the frame-store write arbiter.
 * Models the line buffers and an AXI write slave with random stalls, runs a table
 * of bursts and checks requests, addresses and data against a reference model.
 */
`timescale 1ns/100ps

module frame_wr_tb;

    localparam int NUM_ROWS = 16;
    localparam int TIMEOUT  = 200;          // cycles per wait

    logic                                               clk;
    logic                                               rst;
    logic [frame_wr_pkg::NUM_CH-1:0]                    ch_rready;
    logic [frame_wr_pkg::NUM_CH-1:0]                    frame_end;
    frame_wr_pkg::data_t [frame_wr_pkg::NUM_CH-1:0]     ch_data;
    logic [frame_wr_pkg::NUM_CH-1:0]                    ch_rvalid;
    frame_wr_pkg::buf_addr_t [frame_wr_pkg::NUM_CH-1:0] ch_addr;
    frame_wr_pkg::axi_addr_t                            awaddr;
    logic                                               awvalid;
    logic                                               awready;
    frame_wr_pkg::data_t                                wdata;
    logic                                               wvalid;
    logic                                               wlast;
    logic                                               wready;

    // stimulus table with one row per burst
    string row_name  [NUM_ROWS];
    int    row_ch    [NUM_ROWS];
    bit    row_fe    [NUM_ROWS];
    bit    row_stall [NUM_ROWS];

    int line_off [frame_wr_pkg::NUM_CH];    // reference model state
    bit half     [frame_wr_pkg::NUM_CH];
    int buf_ptr  [frame_wr_pkg::NUM_CH];

    logic [31:0]                     rng;
    logic [frame_wr_pkg::NUM_CH-1:0] rdy_next;
    logic [frame_wr_pkg::NUM_CH-1:0] fe_next;
    bit                              stall_on;
    int                              errors;
    bit                              timed_out;

    frame_wr_top dut0 (
        .clk       (clk),
        .rst       (rst),
        .ch_rready (ch_rready),
        .frame_end (frame_end),
        .ch_data   (ch_data),
        .ch_rvalid (ch_rvalid),
        .ch_addr   (ch_addr),
        .awaddr    (awaddr),
        .awvalid   (awvalid),
        .awready   (awready),
        .wdata     (wdata),
        .wvalid    (wvalid),
        .wlast     (wlast),
        .wready    (wready)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // buffer word tagged with channel and read address
    function automatic frame_wr_pkg::data_t model_word(input int c, input int a);
        logic [31:0] word;
        word = {16'hca3e, c[7:0], a[7:0]};
        return {8{word}};
    endfunction

    always_comb begin
        for (int c = 0; c < frame_wr_pkg::NUM_CH; c++) begin
            ch_data[c] = model_word(c, int'(ch_addr[c]));
        end
    end

    task automatic add_row(input int i, input string name, input int ch, input bit fe,
                           input bit stall);
        row_name[i]  = name;
        row_ch[i]    = ch;
        row_fe[i]    = fe;
        row_stall[i] = stall;
    endtask

    task automatic report_mismatch(input string name, input string what,
                                   input logic [255:0] exp, input logic [255:0] act);
        $display("mismatch %s %s: expected %0h actual %0h", name, what, exp, act);
        errors++;
    endtask

    task automatic report_error(input string name, input string msg);
        $display("error in %s: %s", name, msg);
        errors++;
    endtask

    // drives inputs on the rising edge and returns at the falling edge
    task automatic next_cycle();
        @(posedge clk);
        rng = xorshift32(rng);
        ch_rready <= rdy_next;
        frame_end <= fe_next;
        awready   <= stall_on ? rng[2] : 1'b1;
        wready    <= stall_on ? (rng[0] | rng[1]) : 1'b1;
        @(negedge clk);
    endtask

    task automatic run_row(input int i);
        int                              c;
        int                              t;
        int                              n;
        int                              beats;
        frame_wr_pkg::axi_addr_t         exp_addr;
        logic [frame_wr_pkg::NUM_CH-1:0] exp_rvalid;
        c = row_ch[i];
        exp_rvalid = '0;
        exp_rvalid[c] = 1'b1;
        stall_on = row_stall[i];
        rdy_next = '0;
        t = 0;
        while (ch_rvalid == '0) begin
            next_cycle();
            t++;
            if (t > TIMEOUT) begin
                report_error(row_name[i], "timeout waiting for a channel request");
                timed_out = 1'b1;
                return;
            end
        end
        if (ch_rvalid != exp_rvalid) begin
            report_mismatch(row_name[i], "ch_rvalid", exp_rvalid, ch_rvalid);
        end
        if (awvalid || wvalid || wlast) report_error(row_name[i], "AXI valid high during request");
        if (row_fe[i]) begin
            fe_next[c] = 1'b1;
            next_cycle();
            fe_next = '0;
            next_cycle();                   // pulse taken at this edge
            line_off[c] = 0;
            half[c] = ~half[c];
        end
        if (row_stall[i]) begin
            rdy_next = ~exp_rvalid;         // every other channel ready
            n = 3 + int'(rng[7:5]);
            for (int k = 0; k < n; k++) begin
                next_cycle();
                if (ch_rvalid != exp_rvalid) begin
                    report_mismatch(row_name[i], "ch_rvalid stalled", exp_rvalid, ch_rvalid);
                end
                if (awvalid) report_error(row_name[i], "address issued for a channel not ready");
            end
        end
        rdy_next = exp_rvalid;
        t = 0;
        while (!awvalid) begin
            next_cycle();
            t++;
            if (t > TIMEOUT) begin
                report_error(row_name[i], "timeout waiting for awvalid");
                timed_out = 1'b1;
                return;
            end
        end
        rdy_next = '0;
        if (ch_rvalid != '0) report_error(row_name[i], "ch_rvalid still high after the request");
        exp_addr = frame_wr_pkg::axi_addr_t'(c * frame_wr_pkg::CH_SPAN
                   + (half[c] ? frame_wr_pkg::FRAME_SPAN : 0) + line_off[c]);
        if (awaddr != exp_addr) report_mismatch(row_name[i], "awaddr", exp_addr, awaddr);
        t = 0;
        while (!(awvalid && awready)) begin
            next_cycle();
            t++;
            if (t > TIMEOUT) begin
                report_error(row_name[i], "timeout waiting for the address handshake");
                timed_out = 1'b1;
                return;
            end
            if (awaddr != exp_addr) report_mismatch(row_name[i], "awaddr held", exp_addr, awaddr);
        end
        line_off[c] += frame_wr_pkg::BURST_LEN;
        beats = 0;
        t = 0;
        while (beats < frame_wr_pkg::BURST_LEN) begin
            next_cycle();
            t++;
            if (t > TIMEOUT) begin
                report_error(row_name[i], "timeout waiting for write beats");
                timed_out = 1'b1;
                return;
            end
            if (wvalid) begin
                if (wlast != (beats == frame_wr_pkg::BURST_LEN - 1)) begin
                    report_mismatch(row_name[i], "wlast",
                                    beats == frame_wr_pkg::BURST_LEN - 1, wlast);
                end
                if (wready) begin
                    if (ch_addr[c] != frame_wr_pkg::buf_addr_t'(buf_ptr[c])) begin
                        report_mismatch(row_name[i], "ch_addr", buf_ptr[c], ch_addr[c]);
                    end
                    if (wdata != model_word(c, buf_ptr[c])) begin
                        report_mismatch(row_name[i], "wdata", model_word(c, buf_ptr[c]), wdata);
                    end
                    beats++;
                    buf_ptr[c] = (buf_ptr[c] + 1) % (1 << frame_wr_pkg::BUF_ADDR_W);
                end
            end else if (beats > 0) begin
                report_error(row_name[i], "wvalid dropped inside a burst");
            end
        end
    endtask

    initial begin
        clk       = 1'b0;
        rst       = 1'b0;
        ch_rready = '0;
        frame_end = '0;
        awready   = 1'b0;
        wready    = 1'b0;
        rdy_next  = '0;
        fe_next   = '0;
        stall_on  = 1'b0;
        rng       = 32'd97;
        errors    = 0;
        timed_out = 1'b0;
        for (int c = 0; c < frame_wr_pkg::NUM_CH; c++) begin
            line_off[c] = 0;
            half[c]     = 1'b0;
            buf_ptr[c]  = 0;
        end
        //       row  name              ch  fe  stall
        add_row(0,  "ch0_first",       0,  0,  0);
        add_row(1,  "ch1_first",       1,  0,  0);
        add_row(2,  "ch2_first",       2,  0,  0);
        add_row(3,  "ch3_first",       3,  0,  0);
        add_row(4,  "ch0_second",      0,  0,  0);
        add_row(5,  "ch1_frame_end",   1,  1,  0);
        add_row(6,  "ch2_stall",       2,  0,  1);
        add_row(7,  "ch3_fe_stall",    3,  1,  1);
        add_row(8,  "ch0_buf_wrap",    0,  0,  1);
        add_row(9,  "ch1_back_half0",  1,  1,  1);
        add_row(10, "ch2_third",       2,  0,  1);
        add_row(11, "ch3_after_fe",    3,  0,  0);
        add_row(12, "ch0_frame_end",   0,  1,  1);
        add_row(13, "ch1_offset",      1,  0,  1);
        add_row(14, "ch2_frame_end",   2,  1,  0);
        add_row(15, "ch3_last",        3,  0,  1);

        repeat (3) @(posedge clk);
        rst <= 1'b1;
        @(negedge clk);
        if (ch_rvalid != '0 || awvalid || wvalid || wlast) begin
            report_error("reset", "outputs not idle after reset");
        end
        for (int i = 0; i < NUM_ROWS && !timed_out; i++) begin
            run_row(i);
        end

        $display("errors: %0d, timeouts: %0d", errors, timed_out);
        if (errors == 0 && !timed_out) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: verilog/buf_rd_addr.sv
/*
 * Read address counters for the channel line buffers.
 * Only the channel being served advances, one word per completed AXI beat.
 */
`timescale 1ns/100ps

module buf_rd_addr (
    input  logic                                                clk,
    input  logic                                                rst,
    input  frame_wr_pkg::ch_sel_t                               cur_ch,
    input  logic                                                beat,
    output frame_wr_pkg::buf_addr_t [frame_wr_pkg::NUM_CH-1:0]  ch_addr
);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            ch_addr <= '0;
        end else if (beat) begin
            ch_addr[cur_ch] <= ch_addr[cur_ch] + 1'b1;  // wraps at buffer size
        end
    end

endmodule

// File: verilog/burst_beat.sv
/*
 * AXI write data channel of the arbiter.
 * Streams one fixed-length burst after each address handshake, generating wlast
 * from the beat count and taking wdata straight from the served channel's buffer.
 */
`timescale 1ns/100ps

module burst_beat (
    input  logic                                            clk,
    input  logic                                            rst,
    input  frame_wr_pkg::ch_sel_t                           cur_ch,
    input  logic                                            burst_start,
    input  logic                                            wready,
    input  frame_wr_pkg::data_t [frame_wr_pkg::NUM_CH-1:0]  ch_data,
    output logic                                            wvalid,
    output logic                                            wlast,
    output frame_wr_pkg::data_t                             wdata,
    output logic                                            beat,
    output logic                                            burst_done
);

    frame_wr_pkg::beat_cnt_t cnt;

    assign wlast      = (cnt == frame_wr_pkg::beat_cnt_t'(frame_wr_pkg::BURST_LEN - 1));
    assign beat       = wvalid & wready;
    assign burst_done = beat & wlast;
    assign wdata      = ch_data[cur_ch];        // buffer word at current read address

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            wvalid <= 1'b0;
            cnt    <= '0;
        end else begin
            if (burst_start) begin
                wvalid <= 1'b1;
            end else if (burst_done) begin
                wvalid <= 1'b0;
            end
            if (beat) begin
                cnt <= cnt + 1'b1;              // returns to 0 after last beat
            end
        end
    end

    a_wlast_valid: assert property (
        @(posedge clk) disable iff (!rst)
        wlast |-> wvalid
    );

endmodule

// File: verilog/chan_addr_gen.sv
/*
 * DDR write address generation, one region per channel split into two frame halves.
 * Line offset advances one burst per issued address, frame_end restarts the other half.
 */
`timescale 1ns/100ps

module chan_addr_gen (
    input  logic                            clk,
    input  logic                            rst,
    input  frame_wr_pkg::ch_sel_t           cur_ch,
    input  logic                            addr_load,
    input  logic                            burst_start,
    input  logic [frame_wr_pkg::NUM_CH-1:0] frame_end,
    output frame_wr_pkg::axi_addr_t         awaddr
);

    frame_wr_pkg::line_off_t [frame_wr_pkg::NUM_CH-1:0] line_off;
    logic [frame_wr_pkg::NUM_CH-1:0]                    half;

    frame_wr_pkg::axi_addr_t base;
    frame_wr_pkg::axi_addr_t half_off;
    frame_wr_pkg::axi_addr_t next_addr;

    assign base      = frame_wr_pkg::axi_addr_t'(cur_ch)
                     * frame_wr_pkg::axi_addr_t'(frame_wr_pkg::CH_SPAN);
    assign half_off  = half[cur_ch] ? frame_wr_pkg::axi_addr_t'(frame_wr_pkg::FRAME_SPAN) : '0;
    assign next_addr = base + half_off + frame_wr_pkg::axi_addr_t'(line_off[cur_ch]);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            line_off <= '0;
            half     <= '0;
            awaddr   <= '0;
        end else begin
            for (int c = 0; c < frame_wr_pkg::NUM_CH; c++) begin
                if (frame_end[c]) begin             // frame end beats a burst advance
                    line_off[c] <= '0;
                    half[c]     <= ~half[c];
                end else if (burst_start && cur_ch == frame_wr_pkg::ch_sel_t'(c)) begin
                    line_off[c] <= line_off[c]
                                 + frame_wr_pkg::line_off_t'(frame_wr_pkg::BURST_LEN);
                end
            end
            if (addr_load) begin
                awaddr <= next_addr;
            end
        end
    end

    a_awaddr_range: assert property (
        @(posedge clk) disable iff (!rst)
        awaddr < frame_wr_pkg::axi_addr_t'(frame_wr_pkg::NUM_CH * frame_wr_pkg::CH_SPAN)
    );

endmodule

// File: verilog/frame_wr_ctrl.sv
/*
 * Channel rotation FSM of the write arbiter.
 * Asks the current channel for a burst, issues the AXI write address and waits
 * for the burst to finish before moving on to the next channel.
 */
`timescale 1ns/100ps

module frame_wr_ctrl (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [frame_wr_pkg::NUM_CH-1:0] ch_rready,
    input  logic                            awready,
    input  logic                            burst_done,
    output logic [frame_wr_pkg::NUM_CH-1:0] ch_rvalid,
    output logic                            awvalid,
    output frame_wr_pkg::ch_sel_t           cur_ch,
    output logic                            addr_load,
    output logic                            burst_start
);

    frame_wr_pkg::wr_state_t state;
    logic                    req;

    always_comb begin
        ch_rvalid         = '0;
        ch_rvalid[cur_ch] = req;
    end

    assign addr_load   = req & ch_rready[cur_ch];   // request handshake
    assign burst_start = awvalid & awready;         // address handshake

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state   <= frame_wr_pkg::REQ;
            req     <= 1'b0;
            awvalid <= 1'b0;
            cur_ch  <= '0;
        end else begin
            case (state)
                frame_wr_pkg::REQ: begin
                    if (addr_load) begin
                        state   <= frame_wr_pkg::ADDR;
                        req     <= 1'b0;
                        awvalid <= 1'b1;
                    end else begin
                        req <= 1'b1;                // hold until buffer is ready
                    end
                end
                frame_wr_pkg::ADDR: begin
                    if (burst_start) begin
                        state   <= frame_wr_pkg::DATA;
                        awvalid <= 1'b0;
                    end
                end
                frame_wr_pkg::DATA: begin
                    if (burst_done) begin
                        state  <= frame_wr_pkg::REQ;
                        req    <= 1'b1;
                        cur_ch <= cur_ch + 1'b1;    // wraps 3 -> 0
                    end
                end
                default: begin
                    state   <= frame_wr_pkg::REQ;
                    req     <= 1'b0;
                    awvalid <= 1'b0;
                end
            endcase
        end
    end

    a_awvalid_hold: assert property (
        @(posedge clk) disable iff (!rst)
        awvalid && !awready |=> awvalid
    );

    a_rvalid_onehot: assert property (
        @(posedge clk) disable iff (!rst)
        $onehot0(ch_rvalid)
    );

endmodule

// File: verilog/frame_wr_pkg.sv
/*
 * Shared widths, types, address map and FSM states for the frame-store write arbiter.
 * RTL and testbench reference these by scoped names.
 * The fixed AXI fields are tie-off values for the memory-controller wrapper.
 */
package frame_wr_pkg;

    localparam int NUM_CH     = 4;
    localparam int BURST_LEN  = 16;
    localparam int BUF_ADDR_W = 5;          // two bursts per line buffer
    localparam int DATA_W     = 256;
    localparam int AXI_ADDR_W = 28;         // row 15 + bank 3 + column 10
    localparam int LINE_OFF_W = 17;

    localparam int FRAME_SPAN = 40960;      // words per frame half
    localparam int CH_SPAN    = 2 * FRAME_SPAN;

    typedef logic [$clog2(NUM_CH)-1:0]    ch_sel_t;
    typedef logic [$clog2(BURST_LEN)-1:0] beat_cnt_t;
    typedef logic [BUF_ADDR_W-1:0]        buf_addr_t;
    typedef logic [DATA_W-1:0]            data_t;
    typedef logic [AXI_ADDR_W-1:0]        axi_addr_t;
    typedef logic [LINE_OFF_W-1:0]        line_off_t;

    localparam logic [3:0] AXI_AWLEN   = 4'(BURST_LEN - 1);
    localparam logic [2:0] AXI_AWSIZE  = 3'd5;      // 32 bytes per beat
    localparam logic [1:0] AXI_AWBURST = 2'b01;     // incrementing
    localparam logic [3:0] AXI_AWID    = 4'd0;

    typedef enum logic [1:0] {
        REQ,
        ADDR,
        DATA
    } wr_state_t;

endpackage

// File: verilog/frame_wr_top.sv
/*
 * Frame-store write arbiter for four camera channels.
 * Serves the line buffers in rotation and writes each burst to the channel's
 * DDR region over the AXI write address and data channels.
 */
`timescale 1ns/100ps

module frame_wr_top (
    input  logic                                                clk,
    input  logic                                                rst,
    input  logic [frame_wr_pkg::NUM_CH-1:0]                     ch_rready,
    input  logic [frame_wr_pkg::NUM_CH-1:0]                     frame_end,
    input  frame_wr_pkg::data_t [frame_wr_pkg::NUM_CH-1:0]      ch_data,
    output logic [frame_wr_pkg::NUM_CH-1:0]                     ch_rvalid,
    output frame_wr_pkg::buf_addr_t [frame_wr_pkg::NUM_CH-1:0]  ch_addr,
    output frame_wr_pkg::axi_addr_t                             awaddr,
    output logic                                                awvalid,
    input  logic                                                awready,
    output frame_wr_pkg::data_t                                 wdata,
    output logic                                                wvalid,
    output logic                                                wlast,
    input  logic                                                wready
);

    frame_wr_pkg::ch_sel_t cur_ch;
    logic                  addr_load;
    logic                  burst_start;
    logic                  beat;
    logic                  burst_done;

    frame_wr_ctrl ctrl0 (
        .clk         (clk),
        .rst         (rst),
        .ch_rready   (ch_rready),
        .awready     (awready),
        .burst_done  (burst_done),
        .ch_rvalid   (ch_rvalid),
        .awvalid     (awvalid),
        .cur_ch      (cur_ch),
        .addr_load   (addr_load),
        .burst_start (burst_start)
    );

    chan_addr_gen addr0 (
        .clk         (clk),
        .rst         (rst),
        .cur_ch      (cur_ch),
        .addr_load   (addr_load),
        .burst_start (burst_start),
        .frame_end   (frame_end),
        .awaddr      (awaddr)
    );

    buf_rd_addr rdaddr0 (
        .clk     (clk),
        .rst     (rst),
        .cur_ch  (cur_ch),
        .beat    (beat),
        .ch_addr (ch_addr)
    );

    burst_beat beat0 (
        .clk         (clk),
        .rst         (rst),
        .cur_ch      (cur_ch),
        .burst_start (burst_start),
        .wready      (wready),
        .ch_data     (ch_data),
        .wvalid      (wvalid),
        .wlast       (wlast),
        .wdata       (wdata),
        .beat        (beat),
        .burst_done  (burst_done)
    );

endmodule
